// File: src/core_cfg_pkg.sv
package core_cfg_pkg;

    // Width of one integer register value
    parameter int XLEN = 64;

    // Architectural register file geometry
    parameter int REG_ADDR_W = 5;
    parameter int NUM_REGS   = 32;

endpackage

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk,
    input  logic                                rst,
    input  wb_pkg::rf_wr_t                      wr0,
    input  wb_pkg::rf_wr_t                      wr1,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_addr0,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_addr1,
    output logic [core_cfg_pkg::XLEN-1:0]       rd_data0,
    output logic [core_cfg_pkg::XLEN-1:0]       rd_data1
);
    import core_cfg_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Port 0 is applied last so it wins on a shared destination
            if (wr1.en && wr1.dst != '0) begin
                regs[wr1.dst] <= wr1.data;
            end
            if (wr0.en && wr0.dst != '0) begin
                regs[wr0.dst] <= wr0.data;
            end
        end
    end

    // x0 reads as zero
    assign rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];

endmodule

// File: src/retire_counter.sv
`timescale 1ns/1ps

module retire_counter #(
    parameter int unsigned INSTRET_W = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           retire_cnt,
    output logic [INSTRET_W-1:0] instret
);

    logic [INSTRET_W-1:0] step;

    // Zero-extend the per-cycle count to the total width
    assign step = INSTRET_W'(retire_cnt);

    // Wraps at the top of the range like the CSR it feeds
    always_ff @(posedge clk) begin
        if (rst) begin
            instret <= '0;
        end else begin
            instret <= instret + step;
        end
    end

endmodule

// File: src/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  wb_pkg::wb_req_t   ip0_req,
    input  wb_pkg::wb_req_t   ip1_req,
    input  wb_pkg::wb_req_t   lsp_req,
    input  wb_pkg::wb_req_t   md_req,
    input  wb_pkg::wb_req_t   trap_req,
    output logic              ip0_ready,
    output logic              ip1_ready,
    output logic              lsp_ready,
    output logic              md_ready,
    output logic              trap_ready,
    output wb_pkg::rf_wr_t    wr0,
    output wb_pkg::rf_wr_t    wr1,
    output wb_pkg::fwd_buf_t  fwd_buf,
    output logic [2:0]        retire_cnt
);
    import core_cfg_pkg::*;
    import wb_pkg::*;

    // Shared ports are offered in this order starting at index 0
    localparam int      N_ORD            = 4;
    localparam wb_src_e ORDER [N_ORD]    = '{WB_SRC_LSP, WB_SRC_MD, WB_SRC_IP0, WB_SRC_IP1};

    fwd_buf_t              buf_q;
    wb_src_e               src0;
    wb_src_e               src1;
    logic                  trap_wr;
    logic                  ip0_hi;
    logic [N_ORD-1:0]      want;
    logic [N_ORD-1:0]      placed;
    logic                  take_lsp;
    logic                  take_ip0;
    logic                  take_ip1;
    logic                  buf_load;
    logic [REG_ADDR_W-1:0] cap_dst;
    logic [XLEN-1:0]       cap_value;
    logic [4:0]            hs;

    // Builds the write for one port from its selected source
    function automatic rf_wr_t port_write(input wb_src_e src, input wb_req_t lsp,
                                          input wb_req_t md, input wb_req_t ip0,
                                          input wb_req_t ip1, input wb_req_t trap,
                                          input fwd_buf_t fb);
        rf_wr_t w;
        w    = '0;
        w.en = (src != WB_SRC_NONE);
        case (src)
            WB_SRC_BUF: begin
                w.dst  = fb.dst;
                w.data = fb.value;
            end
            WB_SRC_LSP: begin
                w.dst  = lsp.dst;
                w.data = lsp.result;
            end
            WB_SRC_MD: begin
                w.dst  = md.dst;
                w.data = md.result;
            end
            WB_SRC_IP0: begin
                w.dst  = ip0.dst;
                w.data = ip0.result;
            end
            WB_SRC_IP1: begin
                w.dst  = ip1.dst;
                w.data = ip1.result;
            end
            WB_SRC_TRAP: begin
                w.dst  = trap.dst;
                w.data = trap.result;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    assign trap_wr = trap_req.valid & trap_req.wb_en;
    assign ip0_hi  = ip0_req.valid & ip0_req.wb_en & ip0_req.hipri & ~trap_wr;

    // md writes even with wb_en low
    assign want = {ip1_req.valid & ip1_req.wb_en,
                   ip0_req.valid & ip0_req.wb_en,
                   md_req.valid,
                   lsp_req.valid & lsp_req.wb_en};

    always_comb begin
        src0   = WB_SRC_NONE;
        src1   = WB_SRC_NONE;
        placed = '0;
        if (trap_wr) begin
            src0 = WB_SRC_TRAP;
        end else if (ip0_hi) begin
            src0      = WB_SRC_IP0;
            placed[2] = 1'b1;
        end
        // Buffered loser drains first on port 1
        if (buf_q.valid) begin
            src1 = WB_SRC_BUF;
        end
        for (int i = 0; i < N_ORD; i++) begin
            if (want[i] && !placed[i]) begin
                if (src0 == WB_SRC_NONE) begin
                    src0      = ORDER[i];
                    placed[i] = 1'b1;
                end else if (src1 == WB_SRC_NONE) begin
                    src1      = ORDER[i];
                    placed[i] = 1'b1;
                end
            end
        end
    end

    // One loser among lsp, ip0 and ip1 may park in the buffer but md never does
    // A valid buffer drains on port 1 every cycle so it is always free to capture
    assign take_lsp  = want[0] & ~placed[0];
    assign take_ip0  = want[2] & ~placed[2] & ~take_lsp;
    assign take_ip1  = want[3] & ~placed[3] & ~take_lsp & ~take_ip0;
    assign buf_load  = take_lsp | take_ip0 | take_ip1;

    always_comb begin
        if (take_lsp) begin
            cap_dst   = lsp_req.dst;
            cap_value = lsp_req.result;
        end else if (take_ip0) begin
            cap_dst   = ip0_req.dst;
            cap_value = ip0_req.result;
        end else begin
            cap_dst   = ip1_req.dst;
            cap_value = ip1_req.result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_q.valid <= 1'b0;
        end else begin
            buf_q.valid <= buf_load;
        end
        if (buf_load) begin
            buf_q.dst   <= cap_dst;
            buf_q.value <= cap_value;
        end
    end

    assign fwd_buf = buf_q;
    assign wr0     = port_write(src0, lsp_req, md_req, ip0_req, ip1_req, trap_req, buf_q);
    assign wr1     = port_write(src1, lsp_req, md_req, ip0_req, ip1_req, trap_req, buf_q);

    // Retire without write is always accepted
    assign lsp_ready  = ~lsp_req.valid | ~lsp_req.wb_en | placed[0] | take_lsp;
    assign md_ready   = ~md_req.valid | placed[1];
    assign ip0_ready  = ~ip0_req.valid | ~ip0_req.wb_en | placed[2] | take_ip0;
    assign ip1_ready  = ~ip1_req.valid | ~ip1_req.wb_en | placed[3] | take_ip1;
    assign trap_ready = ~trap_req.valid | ~trap_req.wb_en | (src0 == WB_SRC_TRAP);

    assign hs = {trap_req.valid & trap_ready,
                 md_req.valid & md_ready,
                 lsp_req.valid & lsp_ready,
                 ip1_req.valid & ip1_ready,
                 ip0_req.valid & ip0_ready};

    // Handshake count shows up one cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_cnt <= 3'd0;
        end else begin
            retire_cnt <= 3'($countones(hs));
        end
    end

endmodule

// File: src/wb_pkg.sv
package wb_pkg;

    // Result offer from one execution unit
    typedef struct packed {
        logic                                valid;
        // Low for an instruction that retires without a register write
        logic                                wb_en;
        // High priority for port 0, integer pipe 0 only
        logic                                hipri;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] dst;
        logic [core_cfg_pkg::XLEN-1:0]       result;
    } wb_req_t;

    // One register file write port
    typedef struct packed {
        logic                                en;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] dst;
        logic [core_cfg_pkg::XLEN-1:0]       data;
    } rf_wr_t;

    // Collision buffer as seen by issue for forwarding
    typedef struct packed {
        logic                                valid;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] dst;
        logic [core_cfg_pkg::XLEN-1:0]       value;
    } fwd_buf_t;

    // Source driving a write port
    typedef enum logic [2:0] {
        WB_SRC_NONE = 3'd0,
        WB_SRC_BUF  = 3'd1,
        WB_SRC_LSP  = 3'd2,
        WB_SRC_MD   = 3'd3,
        WB_SRC_IP0  = 3'd4,
        WB_SRC_IP1  = 3'd5,
        WB_SRC_TRAP = 3'd6
    } wb_src_e;

endpackage

// File: src/wb_top.sv
`timescale 1ns/1ps

module wb_top #(
    parameter int unsigned INSTRET_W = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  wb_pkg::wb_req_t                     ip0_req,
    input  wb_pkg::wb_req_t                     ip1_req,
    input  wb_pkg::wb_req_t                     lsp_req,
    input  wb_pkg::wb_req_t                     md_req,
    input  wb_pkg::wb_req_t                     trap_req,
    output logic                                ip0_ready,
    output logic                                ip1_ready,
    output logic                                lsp_ready,
    output logic                                md_ready,
    output logic                                trap_ready,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_addr0,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_addr1,
    output logic [core_cfg_pkg::XLEN-1:0]       rd_data0,
    output logic [core_cfg_pkg::XLEN-1:0]       rd_data1,
    output wb_pkg::fwd_buf_t                    fwd_buf,
    output logic [INSTRET_W-1:0]                instret
);
    import wb_pkg::*;

    rf_wr_t     wr0;
    rf_wr_t     wr1;
    logic [2:0] retire_cnt;

    wb_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .ip0_req    (ip0_req),
        .ip1_req    (ip1_req),
        .lsp_req    (lsp_req),
        .md_req     (md_req),
        .trap_req   (trap_req),
        .ip0_ready  (ip0_ready),
        .ip1_ready  (ip1_ready),
        .lsp_ready  (lsp_ready),
        .md_ready   (md_ready),
        .trap_ready (trap_ready),
        .wr0        (wr0),
        .wr1        (wr1),
        .fwd_buf    (fwd_buf),
        .retire_cnt (retire_cnt)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .wr0      (wr0),
        .wr1      (wr1),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    // Total read by the instret CSR
    retire_counter #(
        .INSTRET_W (INSTRET_W)
    ) u_ret (
        .clk        (clk),
        .rst        (rst),
        .retire_cnt (retire_cnt),
        .instret    (instret)
    );

endmodule

// File: tb/wb_props.sv
`timescale 1ns/1ps

module wb_arb_props (
    input logic             clk,
    input logic             rst,
    input wb_pkg::wb_req_t  trap_req,
    input wb_pkg::rf_wr_t   wr0,
    input wb_pkg::rf_wr_t   wr1,
    input wb_pkg::fwd_buf_t fwd_buf
);

    // Reset leaves the collision buffer empty
    buf_empty_after_rst: assert property (@(posedge clk) rst |=> !fwd_buf.valid)
        else $error("collision buffer is valid right after reset");

    // A parked result always drains on port 1
    buf_drains_on_wr1: assert property (@(posedge clk) disable iff (rst)
        fwd_buf.valid |-> (wr1.en && wr1.dst == fwd_buf.dst))
        else $error("collision buffer is valid but port 1 does not write its destination");

    // Trap results own port 0
    trap_owns_wr0: assert property (@(posedge clk) disable iff (rst)
        (trap_req.valid && trap_req.wb_en) |-> (wr0.en && wr0.dst == trap_req.dst))
        else $error("trap write is not placed on port 0");

endmodule

bind wb_arbiter wb_arb_props u_props (
    .clk      (clk),
    .rst      (rst),
    .trap_req (trap_req),
    .wr0      (wr0),
    .wr1      (wr1),
    .fwd_buf  (fwd_buf)
);

// File: tb/wb_tb.sv
`timescale 1ns/1ps

module wb_tb;
    import core_cfg_pkg::*;
    import wb_pkg::*;

    // Reset, directed tests and 1500 random cycles come to about 2000 with margin on top
    localparam int MAX_CYC  = 3000;
    localparam int RAND_CYC = 1500;

    // Expected outcome of one cycle
    // Ready bits run trap, md, lsp, ip1, ip0 from the top
    typedef struct packed {
        logic [4:0] rdy;
        rf_wr_t     w0;
        rf_wr_t     w1;
        fwd_buf_t   nbuf;
    } step_t;

    logic                  clk = 1'b0;
    logic                  rst;
    wb_req_t               ip0_req;
    wb_req_t               ip1_req;
    wb_req_t               lsp_req;
    wb_req_t               md_req;
    wb_req_t               trap_req;
    logic                  ip0_ready;
    logic                  ip1_ready;
    logic                  lsp_ready;
    logic                  md_ready;
    logic                  trap_ready;
    logic [REG_ADDR_W-1:0] rd_addr0;
    logic [REG_ADDR_W-1:0] rd_addr1;
    logic [XLEN-1:0]       rd_data0;
    logic [XLEN-1:0]       rd_data1;
    fwd_buf_t              fwd_buf;
    logic [31:0]           instret;

    // Model state that matches the DUT after the last rising edge
    logic [XLEN-1:0]       regs_m [NUM_REGS];
    fwd_buf_t              buf_m;
    logic [31:0]           cnt_m;
    logic [31:0]           instret_m;
    logic [31:0]           hs_total;
    logic [4:0]            rdy_s;
    string                 test_name;

    wb_top #(
        .INSTRET_W (32)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .ip0_req    (ip0_req),
        .ip1_req    (ip1_req),
        .lsp_req    (lsp_req),
        .md_req     (md_req),
        .trap_req   (trap_req),
        .ip0_ready  (ip0_ready),
        .ip1_ready  (ip1_ready),
        .lsp_ready  (lsp_ready),
        .md_ready   (md_ready),
        .trap_ready (trap_ready),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .fwd_buf    (fwd_buf),
        .instret    (instret)
    );

    function automatic step_t wb_ref_step(input wb_req_t ip0, input wb_req_t ip1,
                                          input wb_req_t lsp, input wb_req_t md,
                                          input wb_req_t trap, input fwd_buf_t fb);
        step_t      s;
        wb_req_t    ord [4];
        logic [3:0] want;
        logic [3:0] got;
        logic [3:0] cap;
        logic       trap_wr;
        s       = '0;
        ord     = '{lsp, md, ip0, ip1};
        want[0] = lsp.valid && lsp.wb_en;
        want[1] = md.valid;
        want[2] = ip0.valid && ip0.wb_en;
        want[3] = ip1.valid && ip1.wb_en;
        got     = '0;
        cap     = '0;
        trap_wr = trap.valid && trap.wb_en;
        if (trap_wr) begin
            s.w0 = '{1'b1, trap.dst, trap.result};
        end else if (want[2] && ip0.hipri) begin
            s.w0   = '{1'b1, ip0.dst, ip0.result};
            got[2] = 1'b1;
        end
        if (fb.valid) begin
            s.w1 = '{1'b1, fb.dst, fb.value};
        end
        for (int i = 0; i < 4; i++) begin
            if (want[i] && !got[i] && !s.w0.en) begin
                s.w0   = '{1'b1, ord[i].dst, ord[i].result};
                got[i] = 1'b1;
            end else if (want[i] && !got[i] && !s.w1.en) begin
                s.w1   = '{1'b1, ord[i].dst, ord[i].result};
                got[i] = 1'b1;
            end
        end
        // A full buffer always drains on port 1, so it can take one loser each cycle
        for (int i = 0; i < 4; i++) begin
            if (i != 1 && want[i] && !got[i] && cap == '0) begin
                s.nbuf = '{1'b1, ord[i].dst, ord[i].result};
                cap[i] = 1'b1;
            end
        end
        s.rdy[0] = !ip0.valid || !ip0.wb_en || got[2] || cap[2];
        s.rdy[1] = !ip1.valid || !ip1.wb_en || got[3] || cap[3];
        s.rdy[2] = !lsp.valid || !lsp.wb_en || got[0] || cap[0];
        s.rdy[3] = !md.valid || got[1];
        s.rdy[4] = !trap.valid || !trap.wb_en || trap_wr;
        return s;
    endfunction

    function automatic wb_req_t make_req(input logic we, input logic hi,
                                         input logic [REG_ADDR_W-1:0] d,
                                         input logic [XLEN-1:0] v);
        return '{1'b1, we, hi, d, v};
    endfunction

    function automatic wb_req_t rand_req(input logic hi_ok);
        wb_req_t r;
        r.valid  = ($urandom % 3) != 0;
        r.wb_en  = ($urandom % 5) != 0;
        r.hipri  = hi_ok && (($urandom % 4) == 0);
        r.dst    = REG_ADDR_W'($urandom);
        r.result = {$urandom, $urandom};
        return r;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // Drives one set of offers and holds each until it is accepted
    task automatic offer(input logic [REG_ADDR_W-1:0] rd, input wb_req_t a0, input wb_req_t a1,
                         input wb_req_t al, input wb_req_t am, input wb_req_t at);
        logic [4:0] pend;
        @(posedge clk);
        ip0_req  <= a0;
        ip1_req  <= a1;
        lsp_req  <= al;
        md_req   <= am;
        trap_req <= at;
        rd_addr1 <= rd;
        pend = {at.valid, am.valid, al.valid, a1.valid, a0.valid};
        while (pend != '0) begin
            @(posedge clk);
            if (pend[0] && rdy_s[0]) ip0_req <= '0;
            if (pend[1] && rdy_s[1]) ip1_req <= '0;
            if (pend[2] && rdy_s[2]) lsp_req <= '0;
            if (pend[3] && rdy_s[3]) md_req <= '0;
            if (pend[4] && rdy_s[4]) trap_req <= '0;
            pend = pend & ~rdy_s;
        end
    endtask

    initial begin
        forever #20 clk = ~clk;
    end

    initial begin : watchdog
        int n;
        n = 0;
        while (n < MAX_CYC) begin
            @(posedge clk);
            n++;
        end
        $display("Run timed out after %0d cycles without finishing the tests", MAX_CYC);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    // Read port 0 sweeps the whole register file
    always @(posedge clk) begin
        rd_addr0 <= rd_addr0 + 1'b1;
    end

    always @(negedge clk) begin : compare
        step_t      e;
        logic [4:0] act_rdy;
        logic [4:0] vld;
        e       = wb_ref_step(ip0_req, ip1_req, lsp_req, md_req, trap_req, buf_m);
        act_rdy = {trap_ready, md_ready, lsp_ready, ip1_ready, ip0_ready};
        vld     = {trap_req.valid, md_req.valid, lsp_req.valid, ip1_req.valid, ip0_req.valid};
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_m[i] = '0;
            end
            buf_m     = '0;
            cnt_m     = 0;
            instret_m = 0;
            hs_total  = 0;
        end else begin
            check_val("ready", 64'(e.rdy), 64'(act_rdy));
            check_val("fwd_buf.valid", 64'(buf_m.valid), 64'(fwd_buf.valid));
            if (buf_m.valid) begin
                check_val("fwd_buf.dst", 64'(buf_m.dst), 64'(fwd_buf.dst));
                check_val("fwd_buf.value", buf_m.value, fwd_buf.value);
            end
            check_val("rd_data0", regs_m[rd_addr0], rd_data0);
            check_val("rd_data1", regs_m[rd_addr1], rd_data1);
            check_val("instret", 64'(instret_m), 64'(instret));
            // Port 0 goes last so it wins a shared destination and x0 stays zero
            if (e.w1.en && e.w1.dst != '0) regs_m[e.w1.dst] = e.w1.data;
            if (e.w0.en && e.w0.dst != '0) regs_m[e.w0.dst] = e.w0.data;
            instret_m = instret_m + cnt_m;
            cnt_m     = $countones(vld & e.rdy);
            hs_total  = hs_total + $countones(vld & act_rdy);
            buf_m     = e.nbuf;
        end
        rdy_s = act_rdy;
    end

    initial begin
        void'($urandom(32'hebd7_7e9c));
        rst       = 1'b1;
        ip0_req   = '0;
        ip1_req   = '0;
        lsp_req   = '0;
        md_req    = '0;
        trap_req  = '0;
        rd_addr0  = '0;
        rd_addr1  = '0;
        rdy_s     = '0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // Idle long enough for the sweep to read every register
        repeat (NUM_REGS) @(posedge clk);

        test_name = "single";
        offer(5'd1, make_req(1, 0, 5'd1, 64'h1111_0000_0000_0001), '0, '0, '0, '0);
        offer(5'd2, '0, make_req(1, 0, 5'd2, 64'h2222_0000_0000_0002), '0, '0, '0);
        offer(5'd3, '0, '0, make_req(1, 0, 5'd3, 64'h3333_0000_0000_0003), '0, '0);
        offer(5'd4, '0, '0, '0, make_req(1, 0, 5'd4, 64'h4444_0000_0000_0004), '0);
        offer(5'd5, '0, '0, '0, '0, make_req(1, 0, 5'd5, 64'h5555_0000_0000_0005));
        offer(5'd0, '0, '0, make_req(1, 0, 5'd0, 64'hdead_beef_dead_beef), '0, '0);

        test_name = "priority";
        offer(5'd10, make_req(1, 1, 5'd10, 64'ha0), make_req(1, 0, 5'd11, 64'ha1),
              make_req(1, 0, 5'd12, 64'ha2), make_req(1, 0, 5'd13, 64'ha3),
              make_req(1, 0, 5'd14, 64'ha4));
        offer(5'd15, make_req(1, 1, 5'd15, 64'hb0), '0, make_req(1, 0, 5'd16, 64'hb2),
              make_req(1, 0, 5'd17, 64'hb3), '0);
        offer(5'd20, make_req(1, 0, 5'd20, 64'hc0), make_req(1, 0, 5'd21, 64'hc1),
              make_req(1, 0, 5'd22, 64'hc2), make_req(1, 0, 5'd23, 64'hc3), '0);
        offer(5'd25, '0, '0, make_req(1, 0, 5'd25, 64'hd2), make_req(1, 0, 5'd25, 64'hd3), '0);

        test_name = "no_write";
        offer(5'd9, make_req(0, 1, 5'd9, 64'he0), make_req(0, 0, 5'd9, 64'he1),
              make_req(0, 0, 5'd9, 64'he2), '0, make_req(0, 0, 5'd9, 64'he4));

        test_name = "random";
        repeat (RAND_CYC) begin
            @(posedge clk);
            if (!ip0_req.valid || rdy_s[0]) ip0_req <= rand_req(1'b1);
            if (!ip1_req.valid || rdy_s[1]) ip1_req <= rand_req(1'b0);
            if (!lsp_req.valid || rdy_s[2]) lsp_req <= rand_req(1'b0);
            if (!md_req.valid || rdy_s[3]) md_req <= rand_req(1'b0);
            if (!trap_req.valid || rdy_s[4]) trap_req <= rand_req(1'b0);
            rd_addr1 <= REG_ADDR_W'($urandom);
        end
        // Held offers complete before the total is compared
        @(posedge clk);
        while (ip0_req.valid || ip1_req.valid || lsp_req.valid || md_req.valid ||
               trap_req.valid) begin
            if (rdy_s[0]) ip0_req <= '0;
            if (rdy_s[1]) ip1_req <= '0;
            if (rdy_s[2]) lsp_req <= '0;
            if (rdy_s[3]) md_req <= '0;
            if (rdy_s[4]) trap_req <= '0;
            @(posedge clk);
        end

        test_name = "instret";
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_val("instret total", 64'(hs_total), 64'(instret));
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: wb_core.f
src/core_cfg_pkg.sv
src/wb_pkg.sv
src/wb_arbiter.sv
src/reg_file.sv
src/retire_counter.sv
src/wb_top.sv
tb/wb_props.sv
tb/wb_tb.sv
